/* pcimt_pkg.sv */
// PCI target shared definitions

package pcimt_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // PCI bus commands
    ////////////////////////////////////////////////////////////////////////////

    // command codes as they appear on C/BE# during the address phase
    localparam logic [3:0] CMD_MEM_RD = 4'b0110;
    localparam logic [3:0] CMD_MEM_WR = 4'b0111;

    ////////////////////////////////////////////////////////////////////////////
    // target machine states
    ////////////////////////////////////////////////////////////////////////////

    // the same encoding is seen by the core and by anything that reports on it
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        CLAIM    = 3'd1,
        WR_DATA  = 3'd2,
        APB_WAIT = 3'd3,
        RD_DRIVE = 3'd4,
        TURN     = 3'd5
    } targ_state_t;

    // window size is 2**BAR_BITS bytes, 4 KB unless the top level says otherwise
    localparam int BAR_BITS_DEF = 12;

    // the base must be aligned to the window size
    localparam logic [31:0] BAR_BASE_DEF = 32'h8000_0000;

endpackage

/* pcimt32_dp.sv */
// PCI AD data path register

`timescale 1ns/1ps

module pcimt32_dp
(
    input  logic        Clk_in,
    input  logic        Rstn_in,
    input  logic        ld_bus,
    input  logic        ld_apb,
    input  logic [31:0] ad_in,
    input  logic [31:0] prdata,
    output logic [31:0] ad_reg
);

    // next value of the register, chosen from bus word, APB word or itself
    logic [31:0] ad_d;

    // the target FSM never raises both loads in the same cycle
    // so their order in this mux carries no meaning
    // with neither load active the register feeds itself back and holds
    always_comb
    begin
        if (ld_bus)
        begin
            ad_d = ad_in;
        end
        else if (ld_apb)
        begin
            ad_d = prdata;
        end
        else
        begin
            ad_d = ad_reg;
        end
    end

    // a write word sits here while the APB transfer runs
    // and a read word sits here while the initiator inserts wait states
    always_ff @(posedge Clk_in or negedge Rstn_in)
    begin
        if (!Rstn_in)
        begin
            ad_reg <= 32'h0;
        end
        else
        begin
            ad_reg <= ad_d;
        end
    end

endmodule

/* pcimt32_targ_fsm.sv */
// PCI target state machine

`timescale 1ns/1ps

module pcimt32_targ_fsm
#(
    parameter logic [31:0] BAR_BASE = pcimt_pkg::BAR_BASE_DEF,
    parameter int          BAR_BITS = pcimt_pkg::BAR_BITS_DEF
)
(
    input  logic                Clk_in,
    input  logic                Rstn_in,
    input  logic                frame_n,
    input  logic                irdy_n,
    input  logic [3:0]          cbe_n,
    input  logic [31:0]         ad_in,
    input  logic                apb_done,
    output logic                devsel_n,
    output logic                trdy_n,
    output logic                ad_oe,
    output logic                ld_bus,
    output logic                ld_apb,
    output logic                apb_req,
    output logic                apb_write,
    output logic [BAR_BITS-1:0] apb_addr
);

    pcimt_pkg::targ_state_t state_q;

    // set when frame_n and irdy_n were both high on the previous clock
    logic bus_idle_q;
    // direction of the claimed transaction, kept for the whole transaction
    logic is_write;

    logic addr_phase;
    logic cmd_ok;
    logic bar_hit;
    logic claim;
    logic xfer_done;

    ////////////////////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // first clock with frame_n low after an idle bus clock
        // a frame that starts while the target is still busy is never seen here
        addr_phase = !frame_n && bus_idle_q;

        // only memory read and memory write are decoded
        cmd_ok = (cbe_n == pcimt_pkg::CMD_MEM_RD) || (cbe_n == pcimt_pkg::CMD_MEM_WR);

        // upper address bits select the window and lower bits give the offset
        bar_hit = (ad_in[31:BAR_BITS] == BAR_BASE[31:BAR_BITS]);

        claim = (state_q == pcimt_pkg::IDLE) && addr_phase && cmd_ok && bar_hit;

        // a data phase completes when both ready signals are low together
        xfer_done = !irdy_n && !trdy_n;
    end

    ////////////////////////////////////////////////////////////////////////////
    // data path and APB strobes
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // write data is taken on the first clock the initiator has it ready
        ld_bus = (state_q == pcimt_pkg::CLAIM) && is_write && !irdy_n;

        // a read asks the APB side right after the claim
        // a write asks one clock after its data was captured
        apb_req = ((state_q == pcimt_pkg::CLAIM) && !is_write)
                || (state_q == pcimt_pkg::WR_DATA);

        // read data is captured on the clock the APB transfer completes
        ld_apb = (state_q == pcimt_pkg::APB_WAIT) && apb_done && !is_write;
    end

    assign apb_write = is_write;

    ////////////////////////////////////////////////////////////////////////////
    // state register and PCI outputs
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk_in or negedge Rstn_in)
    begin
        if (!Rstn_in)
        begin
            state_q    <= pcimt_pkg::IDLE;
            devsel_n   <= 1'b1;
            trdy_n     <= 1'b1;
            ad_oe      <= 1'b0;
            is_write   <= 1'b0;
            bus_idle_q <= 1'b1;
            apb_addr   <= '0;
        end
        else
        begin
            bus_idle_q <= frame_n && irdy_n;

            case (state_q)
                pcimt_pkg::IDLE:
                begin
                    // fast decode drives DEVSEL# one clock after the address phase
                    if (claim)
                    begin
                        state_q  <= pcimt_pkg::CLAIM;
                        devsel_n <= 1'b0;
                        is_write <= (cbe_n == pcimt_pkg::CMD_MEM_WR);
                        apb_addr <= ad_in[BAR_BITS-1:0];
                    end
                end

                // a read raises its request in this state and moves on
                // while a write waits here for the initiator to put its data up
                pcimt_pkg::CLAIM:
                begin
                    if (!is_write)
                    begin
                        state_q <= pcimt_pkg::APB_WAIT;
                    end
                    else if (!irdy_n)
                    begin
                        state_q <= pcimt_pkg::WR_DATA;
                    end
                end

                // the captured write word goes out with the request of this clock
                pcimt_pkg::WR_DATA:
                begin
                    state_q <= pcimt_pkg::APB_WAIT;
                end

                // TRDY# stays off until the APB side reports the transfer done
                pcimt_pkg::APB_WAIT:
                begin
                    if (apb_done)
                    begin
                        state_q <= pcimt_pkg::RD_DRIVE;
                        trdy_n  <= 1'b0;
                        ad_oe   <= !is_write;
                    end
                end

                // the data phase of both directions waits here and only a read drives AD
                pcimt_pkg::RD_DRIVE:
                begin
                    if (xfer_done)
                    begin
                        state_q  <= pcimt_pkg::TURN;
                        devsel_n <= 1'b1;
                        trdy_n   <= 1'b1;
                        ad_oe    <= 1'b0;
                    end
                end

                // one clock of turnaround before another address phase is decoded
                pcimt_pkg::TURN:
                begin
                    state_q <= pcimt_pkg::IDLE;
                end

                default:
                begin
                    state_q <= pcimt_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

/* pcimt32_apb_mst.sv */
// APB master for the PCI target

`timescale 1ns/1ps

module pcimt32_apb_mst
#(
    parameter int BAR_BITS = pcimt_pkg::BAR_BITS_DEF
)
(
    input  logic                Clk_in,
    input  logic                Rstn_in,
    input  logic                apb_req,
    input  logic                apb_write,
    input  logic [BAR_BITS-1:0] apb_addr,
    input  logic                pready,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output logic [BAR_BITS-1:0] paddr,
    output logic                apb_done
);

    // idle, setup phase and access phase of one APB transfer
    typedef enum logic [1:0] {
        APB_IDLE   = 2'd0,
        APB_SETUP  = 2'd1,
        APB_ACCESS = 2'd2
    } apb_state_t;

    apb_state_t state_q;

    ////////////////////////////////////////////////////////////////////////////
    // transfer sequencing
    ////////////////////////////////////////////////////////////////////////////

    // the requester waits for apb_done before it asks again
    // so a request can only arrive in the idle state
    always_ff @(posedge Clk_in or negedge Rstn_in)
    begin
        if (!Rstn_in)
        begin
            state_q <= APB_IDLE;
        end
        else
        begin
            case (state_q)
                APB_IDLE:
                begin
                    if (apb_req)
                    begin
                        state_q <= APB_SETUP;
                    end
                end

                // setup always lasts exactly one clock
                APB_SETUP:
                begin
                    state_q <= APB_ACCESS;
                end

                // the slave stretches the access phase with pready low
                APB_ACCESS:
                begin
                    if (pready)
                    begin
                        state_q <= APB_IDLE;
                    end
                end

                default:
                begin
                    state_q <= APB_IDLE;
                end
            endcase
        end
    end

    // address and direction are captured with the request
    // and stay put through setup and every wait state
    always_ff @(posedge Clk_in)
    begin
        if ((state_q == APB_IDLE) && apb_req)
        begin
            paddr  <= apb_addr;
            pwrite <= apb_write;
        end
    end

    // both strobes come straight from the state register
    assign psel     = (state_q != APB_IDLE);
    assign penable  = (state_q == APB_ACCESS);

    // completing clock of the transfer, high for one clock only
    assign apb_done = (state_q == APB_ACCESS) && pready;

endmodule

/* pcimt32_top.sv */
// PCI target to APB bridge top

`timescale 1ns/1ps

module pcimt32_top
#(
    parameter logic [31:0] BAR_BASE = pcimt_pkg::BAR_BASE_DEF,
    parameter int          BAR_BITS = pcimt_pkg::BAR_BITS_DEF
)
(
    input  logic                Clk_in,
    input  logic                Rstn_in,

    // PCI target side, the AD bus is split into input, output and enable
    input  logic                frame_n,
    input  logic                irdy_n,
    input  logic [3:0]          cbe_n,
    input  logic [31:0]         ad_in,
    output logic [31:0]         ad_out,
    output logic                ad_oe,
    output logic                devsel_n,
    output logic                trdy_n,

    // APB master side
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output logic [BAR_BITS-1:0] paddr,
    output logic [31:0]         pwdata,
    input  logic [31:0]         prdata,
    input  logic                pready
);

    ////////////////////////////////////////////////////////////////////////////
    // internal connections
    ////////////////////////////////////////////////////////////////////////////

    logic                ld_bus;
    logic                ld_apb;
    logic [31:0]         ad_reg;
    logic                apb_req;
    logic                apb_write;
    logic                apb_done;
    logic [BAR_BITS-1:0] apb_addr;

    // one register carries the word in both directions
    assign ad_out = ad_reg;
    assign pwdata = ad_reg;

    pcimt32_dp u_dp
    (
        .Clk_in  (Clk_in),
        .Rstn_in (Rstn_in),
        .ld_bus  (ld_bus),
        .ld_apb  (ld_apb),
        .ad_in   (ad_in),
        .prdata  (prdata),
        .ad_reg  (ad_reg)
    );

    pcimt32_targ_fsm
    #(
        .BAR_BASE (BAR_BASE),
        .BAR_BITS (BAR_BITS)
    )
    u_targ
    (
        .Clk_in    (Clk_in),
        .Rstn_in   (Rstn_in),
        .frame_n   (frame_n),
        .irdy_n    (irdy_n),
        .cbe_n     (cbe_n),
        .ad_in     (ad_in),
        .apb_done  (apb_done),
        .devsel_n  (devsel_n),
        .trdy_n    (trdy_n),
        .ad_oe     (ad_oe),
        .ld_bus    (ld_bus),
        .ld_apb    (ld_apb),
        .apb_req   (apb_req),
        .apb_write (apb_write),
        .apb_addr  (apb_addr)
    );

    pcimt32_apb_mst
    #(
        .BAR_BITS (BAR_BITS)
    )
    u_apb
    (
        .Clk_in    (Clk_in),
        .Rstn_in   (Rstn_in),
        .apb_req   (apb_req),
        .apb_write (apb_write),
        .apb_addr  (apb_addr),
        .pready    (pready),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .apb_done  (apb_done)
    );

endmodule

/* pcimt32_checker.sv */
// PCI target bus checker

`timescale 1ns/1ps

module pcimt32_checker
#(
    parameter int NVEC     = 10,
    parameter int BAR_BITS = pcimt_pkg::BAR_BITS_DEF
)
(
    input  logic                Clk_in,
    input  logic                Rstn_in,
    input  logic                frame_n,
    input  logic                irdy_n,
    input  logic [3:0]          cbe_n,
    input  logic [31:0]         ad_out,
    input  logic                ad_oe,
    input  logic                devsel_n,
    input  logic                trdy_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [BAR_BITS-1:0] paddr,
    input  logic [31:0]         pwdata,
    input  logic                pready,
    input  int                  vec_idx,
    output int                  err_cnt,
    output int                  done_cnt
);

    // same line layout as the stimulus side reads
    logic [79:0] vec [NVEC];
    // window words as the writes so far have left them, keyed by byte offset
    logic [31:0] model [int];

    logic        active;
    logic        idle_chk;
    logic        frame_q;
    logic        is_wr;
    logic        claim_exp;
    logic        held_v;
    logic [31:0] cur_addr;
    logic [31:0] cur_data;
    logic [31:0] exp_rd;
    logic [31:0] held_ad;
    int          idx;
    int          age;
    int          apb_cnt;
    int          test_err;

    initial
    begin
        $readmemh("pcimt32_vectors.txt", vec);
    end

    task check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("Error: %0t ns %s expected %h, got %h", $time, name, exp, act);
            err_cnt++;
            test_err++;
        end
    endtask

    task report_fail(input string what);
        $display("failure at %0t ns: %s", $time, what);
        err_cnt++;
        test_err++;
    endtask

    task close_test();
        $display("vector %0d %s at %h: %s", idx, is_wr ? "write" : "read", cur_addr,
                 (test_err == 0) ? "ok" : "failed");
        done_cnt++;
        active   = 1'b0;
        idle_chk = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sampling on the rising edge sees the values held through the cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge Clk_in or negedge Rstn_in)
    begin
        if (!Rstn_in)
        begin
            active   = 1'b0;
            idle_chk = 1'b1;
            frame_q  = 1'b1;
            err_cnt  = 0;
            done_cnt = 0;
        end
        else
        begin
            // bus outputs at rest after reset and after each transaction
            if (idle_chk)
            begin
                check_value("devsel_n", 32'd1, {31'd0, devsel_n});
                check_value("trdy_n", 32'd1, {31'd0, trdy_n});
                check_value("ad_oe", 32'd0, {31'd0, ad_oe});
                check_value("psel", 32'd0, {31'd0, psel});
                check_value("penable", 32'd0, {31'd0, penable});
                idle_chk = 1'b0;
            end

            if (!active && !frame_n && frame_q)
            begin
                // the vector of this address phase says what the target should make of it
                idx       = vec_idx;
                cur_addr  = vec[idx][75:44];
                cur_data  = vec[idx][43:12];
                claim_exp = vec[idx][8];
                is_wr     = (cbe_n == pcimt_pkg::CMD_MEM_WR);
                active    = 1'b1;
                held_v    = 1'b0;
                age       = 0;
                apb_cnt   = 0;
                test_err  = 0;
            end
            else if (active)
            begin
                age++;
                if (age == 1)
                begin
                    check_value("devsel_n", claim_exp ? 32'd0 : 32'd1, {31'd0, devsel_n});
                end
                if (!claim_exp && (!devsel_n || psel))
                begin
                    report_fail("an unclaimed transaction reached DEVSEL# or the APB port");
                end

                // TRDY# may only fall once the APB side has finished
                if (claim_exp && !trdy_n && (apb_cnt == 0))
                begin
                    report_fail("TRDY# fell before the APB transfer ended");
                end

                if (psel && penable && pready)
                begin
                    apb_cnt++;
                    check_value("pwrite", {31'd0, is_wr}, {31'd0, pwrite});
                    check_value("paddr", {20'd0, cur_addr[BAR_BITS-1:0]}, {20'd0, paddr});
                    if (is_wr)
                    begin
                        check_value("pwdata", cur_data, pwdata);
                        model[cur_addr[BAR_BITS-1:0]] = cur_data;
                    end
                    else if (model.exists(cur_addr[BAR_BITS-1:0]))
                    begin
                        exp_rd = model[cur_addr[BAR_BITS-1:0]];
                    end
                    else
                    begin
                        report_fail("read of a word that no earlier write has set");
                        exp_rd = 'x;
                    end
                end

                // during initiator wait states the target must sit still
                if (held_v && trdy_n)
                begin
                    report_fail("TRDY# released before the data phase completed");
                end
                if (!trdy_n && irdy_n)
                begin
                    if (held_v)
                    begin
                        check_value("ad_out", held_ad, ad_out);
                    end
                    held_ad = ad_out;
                    held_v  = 1'b1;
                end

                if (!irdy_n && !trdy_n)
                begin
                    check_value("APB transfer count", 32'd1, apb_cnt);
                    // AD is driven on the completing clock of a read and never for a write
                    check_value("ad_oe", {31'd0, !is_wr}, {31'd0, ad_oe});
                    if (!is_wr)
                    begin
                        check_value("ad_out", exp_rd, ad_out);
                    end
                    close_test();
                end
                else if (!claim_exp && (age == 5))
                begin
                    close_test();
                end
            end

            frame_q = frame_n;
        end
    end

endmodule

/* pcimt32_tb.sv */
// PCI target bridge testbench

`timescale 1ns/1ps

module pcimt32_tb;

    localparam int NVEC = 10;

    logic        Clk_in;
    logic        Rstn_in;
    logic        frame_n;
    logic        irdy_n;
    logic [3:0]  cbe_n;
    logic [31:0] ad_in;
    logic [31:0] ad_out;
    logic        ad_oe;
    logic        devsel_n;
    logic        trdy_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;

    logic [79:0] vec [NVEC];
    // APB slave storage, one word per paddr[9:2]
    logic [31:0] mem [256];
    int          vec_idx;
    int          cur_aw;
    int          apb_wait;
    int          err_cnt;
    int          done_cnt;

    pcimt32_top u_pcimt32_top
    (
        .Clk_in (Clk_in), .Rstn_in (Rstn_in),
        .frame_n (frame_n), .irdy_n (irdy_n), .cbe_n (cbe_n), .ad_in (ad_in),
        .ad_out (ad_out), .ad_oe (ad_oe), .devsel_n (devsel_n), .trdy_n (trdy_n),
        .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
        .pwdata (pwdata), .prdata (prdata), .pready (pready)
    );

    pcimt32_checker #(.NVEC (NVEC)) u_checker
    (
        .Clk_in (Clk_in), .Rstn_in (Rstn_in),
        .frame_n (frame_n), .irdy_n (irdy_n), .cbe_n (cbe_n),
        .ad_out (ad_out), .ad_oe (ad_oe), .devsel_n (devsel_n), .trdy_n (trdy_n),
        .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
        .pwdata (pwdata), .pready (pready), .vec_idx (vec_idx),
        .err_cnt (err_cnt), .done_cnt (done_cnt)
    );

    initial
    begin
        Clk_in = 1'b0;
        forever #4 Clk_in = ~Clk_in;
    end

    ////////////////////////////////////////////////////////////////////////////
    // APB slave memory
    ////////////////////////////////////////////////////////////////////////////

    assign prdata = mem[paddr[9:2]];

    always @(posedge Clk_in)
    begin
        if (psel && penable && pready && pwrite)
        begin
            mem[paddr[9:2]] <= pwdata;
        end
    end

    // the wait count is drawn in setup and counted down through the access phase
    always @(negedge Clk_in)
    begin
        if (psel && !penable)
        begin
            apb_wait = (cur_aw < 0) ? $urandom_range(3, 0) : cur_aw;
            pready   = (apb_wait == 0);
        end
        else if (psel && penable && !pready)
        begin
            apb_wait--;
            pready = (apb_wait == 0);
        end
        else if (!psel)
        begin
            pready = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // PCI initiator
    ////////////////////////////////////////////////////////////////////////////

    task run_vector(input int i);
        logic signed [3:0] aw;
        int                iw;
        aw = vec[i][3:0];
        iw = vec[i][7:4];
        @(negedge Clk_in);
        vec_idx = i;
        cur_aw  = aw;
        frame_n = 1'b0;
        cbe_n   = vec[i][79:76];
        ad_in   = vec[i][75:44];
        @(negedge Clk_in);
        cbe_n = 4'h0;
        ad_in = (vec[i][79:76] == pcimt_pkg::CMD_MEM_WR) ? vec[i][43:12] : 32'h0;
        if (!vec[i][8])
        begin
            // master abort, nobody answers within five clocks
            frame_n = 1'b1;
            irdy_n  = 1'b0;
            repeat (5) @(negedge Clk_in);
        end
        else
        begin
            // a read holds IRDY# off until the target has its word up
            if (vec[i][79:76] != pcimt_pkg::CMD_MEM_WR)
            begin
                while (trdy_n)
                begin
                    @(negedge Clk_in);
                end
            end
            repeat (iw) @(negedge Clk_in);
            frame_n = 1'b1;
            irdy_n  = 1'b0;
            while (trdy_n)
            begin
                @(negedge Clk_in);
            end
            @(negedge Clk_in);
        end
        irdy_n = 1'b1;
        repeat (2) @(negedge Clk_in);
    endtask

    initial
    begin
        void'($urandom(30304));
        $readmemh("pcimt32_vectors.txt", vec);
        for (int a = 0; a < 256; a++)
        begin
            mem[a] = 32'h6C00_0000 ^ (a * 32'h0001_0203);
        end
        Rstn_in = 1'b0;
        frame_n = 1'b1;
        irdy_n  = 1'b1;
        cbe_n   = 4'h0;
        ad_in   = 32'h0;
        pready  = 1'b0;
        vec_idx = 0;
        cur_aw  = 0;
        repeat (8) @(posedge Clk_in);
        @(negedge Clk_in);
        Rstn_in = 1'b1;
        for (int i = 0; i < NVEC; i++)
        begin
            run_vector(i);
        end
        repeat (4) @(negedge Clk_in);
        $display("tests done %0d of %0d, errors %0d", done_cnt, NVEC, err_cnt);
        if ((err_cnt == 0) && (done_cnt == NVEC))
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

    // forty clocks per vector plus reset and a short tail
    initial
    begin
        #((8 + 10 + 40 * NVEC) * 8);
        $display("watchdog: the vectors did not finish in time, run stopped");
        $display("** FAIL **");
        $finish;
    end

endmodule

/* pcimt32_vectors.txt */
// columns: command on C/BE#, address, data, expected claim, initiator waits, APB waits
// one 80-bit hex word per line with fields split by underscores, APB waits of f mean random
7_80000010_DEADBEEF_1_0_0
6_80000010_00000000_1_0_0
7_80000FFC_12345678_1_2_1
6_80000FFC_00000000_1_3_2
7_80000100_A5A55A5A_1_0_F
6_80000100_00000000_1_1_F
6_90000010_00000000_0_0_0
2_80000010_00000000_0_0_0
7_80000010_CAFEF00D_1_1_F
6_80000010_00000000_1_0_F

/* all.f */
pcimt_pkg.sv
pcimt32_dp.sv
pcimt32_targ_fsm.sv
pcimt32_apb_mst.sv
pcimt32_top.sv
pcimt32_checker.sv
pcimt32_tb.sv

/* Makefile */
# Verilator build for the PCI target bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module pcimt32_top

sim:
	verilator --binary --timing -f all.f --top-module pcimt32_tb -o pcimt32_sim
	./obj_dir/pcimt32_sim | tee sim.log
	grep -qF "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log
